/* bench/memory_control_assert.sv */
// handshake checks for the memory controller
// response hold under back-pressure, snoop target and post-reset outputs
`include "coherence_settings.svh"

module memory_control_assert (
  input logic                      CLK,
  input logic                      nRST,
  input coherence_pkg::mem_resp_t  resp [`NUM_CORES],
  input logic [`NUM_CORES-1:0]     resp_valid,
  input logic [`NUM_CORES-1:0]     resp_ready,
  input logic [`NUM_CORES-1:0]     snoop_valid,
  input coherence_pkg::mem_req_t   snp_req,
  input logic                      snp_valid,
  input logic                      snp_ready
);
  import coherence_pkg::*;

  for (genvar c = 0; c < `NUM_CORES; c++) begin : g_core
    // held response keeps its payload
    assert property (@(posedge CLK) disable iff (!nRST)
      resp_valid[c] && !resp_ready[c] |=> resp_valid[c] && $stable(resp[c]))
      else $error("response on core %0d changed while held", c);
  end

  // data request taken by the snoop stage snoops only the other core
  assert property (@(posedge CLK) disable iff (!nRST)
    snp_valid && snp_ready && snp_req.kind != REQ_IFETCH
      |=> snoop_valid == ($past(snp_req.core) ? 2'b01 : 2'b10))
    else $error("snoop not sent to the other core only");

  assert property (@(posedge CLK)
    $rose(nRST) |-> resp_valid == '0 && snoop_valid == '0)
    else $error("valid output high right after reset");

endmodule

bind memory_control memory_control_assert chk (
  .CLK, .nRST, .resp, .resp_valid, .resp_ready, .snoop_valid,
  .snp_req, .snp_valid, .snp_ready
);

/* bench/memory_control_tb.sv */
// testbench for the two-core memory controller
// directed tests with snoop responder models for both cores
`include "coherence_settings.svh"

module memory_control_tb;
  import coherence_pkg::*;

  localparam int TIMEOUT = 300;

  logic                  CLK;
  logic                  nRST;
  mem_req_t              req [`NUM_CORES];
  logic [`NUM_CORES-1:0] req_valid;
  logic [`NUM_CORES-1:0] req_ready;
  mem_resp_t             resp [`NUM_CORES];
  logic [`NUM_CORES-1:0] resp_valid;
  logic [`NUM_CORES-1:0] resp_ready;
  snoop_req_t            snoop_req [`NUM_CORES];
  logic [`NUM_CORES-1:0] snoop_valid;
  logic [`NUM_CORES-1:0] snoop_ready;
  snoop_resp_t           snoop_resp [`NUM_CORES];
  logic [`NUM_CORES-1:0] snoop_resp_valid;

  int value_errs;
  int other_errs;

  // snoop responder state, one dirty word per core
  logic               dirty_on [`NUM_CORES];
  logic [`ADDR_W-1:0] dirty_addr [`NUM_CORES];
  logic [`DATA_W-1:0] dirty_data [`NUM_CORES];
  logic               busy [`NUM_CORES];
  int                 delay [`NUM_CORES];
  logic               snp_hit;

  int                 snp_core_q [$];
  logic [`ADDR_W-1:0] snp_addr_q [$];
  logic               snp_inv_q [$];
  int                 resp_core_q [$];
  logic [`DATA_W-1:0] resp_data_q [$];

  logic [`ADDR_W-1:0] wr_addr [4];
  logic [`DATA_W-1:0] wr_data [4];

  tb_clock clk_gen (.CLK);

  memory_control uut (
    .CLK, .nRST, .req, .req_valid, .req_ready, .resp, .resp_valid, .resp_ready,
    .snoop_req, .snoop_valid, .snoop_ready, .snoop_resp, .snoop_resp_valid
  );

  // answers after 0 to 3 cycles, valid for one cycle
  always @(negedge CLK) begin
    for (int c = 0; c < `NUM_CORES; c++) begin
      if (!nRST) begin
        busy[c] = 1'b0;
        snoop_resp_valid[c] = 1'b0;
      end else if (snoop_resp_valid[c]) begin
        snoop_resp_valid[c] = 1'b0;
        busy[c] = 1'b0;
      end else if (!busy[c] && snoop_valid[c]) begin
        busy[c] = 1'b1;
        delay[c] = $urandom_range(3, 0);
        snp_core_q.push_back(c);
        snp_addr_q.push_back(snoop_req[c].addr);
        snp_inv_q.push_back(snoop_req[c].inv);
        snp_hit = dirty_on[c] && (dirty_addr[c] == snoop_req[c].addr);
        snoop_resp[c].hit   = snp_hit;
        snoop_resp[c].dirty = snp_hit;
        snoop_resp[c].data  = snp_hit ? dirty_data[c] : '0;
        // word leaves the cache either way
        if (snp_hit) begin
          dirty_on[c] = 1'b0;
        end
        if (delay[c] == 0) begin
          snoop_resp_valid[c] = 1'b1;
        end
      end else if (busy[c]) begin
        delay[c] = delay[c] - 1;
        if (delay[c] == 0) begin
          snoop_resp_valid[c] = 1'b1;
        end
      end
    end
  end

  // completed responses in order
  always @(posedge CLK) begin
    if (nRST) begin
      for (int c = 0; c < `NUM_CORES; c++) begin
        if (resp_valid[c] && resp_ready[c]) begin
          resp_core_q.push_back(c);
          resp_data_q.push_back(resp[c].rdata);
        end
      end
    end
  end

  task automatic drive_reset();
    @(negedge CLK);
    nRST = 1'b0;
    repeat (3) @(negedge CLK);
    nRST = 1'b1;
  endtask

  task automatic clear_logs();
    snp_core_q.delete();
    snp_addr_q.delete();
    snp_inv_q.delete();
    resp_core_q.delete();
    resp_data_q.delete();
  endtask

  task automatic send_req(input int c, input req_kind_e kind,
                          input logic [`ADDR_W-1:0] addr, input logic [`DATA_W-1:0] wdata);
    int   n;
    logic done;
    @(negedge CLK);
    req[c].kind  = kind;
    req[c].core  = 1'b0;
    req[c].addr  = addr;
    req[c].wdata = wdata;
    req_valid[c] = 1'b1;
    n = 0;
    done = 1'b0;
    while (!done && n < TIMEOUT) begin
      @(posedge CLK);
      done = req_ready[c];
      n++;
    end
    if (!done) begin
      other_errs++;
      $display("request from core %0d was never accepted", c);
    end
    @(negedge CLK);
    req_valid[c] = 1'b0;
  endtask

  // both cores raise their request on the same edge
  task automatic send_pair(input req_kind_e kind0, input logic [`ADDR_W-1:0] addr0,
                           input req_kind_e kind1, input logic [`ADDR_W-1:0] addr1);
    fork
      send_req(0, kind0, addr0, '0);
      send_req(1, kind1, addr1, '0);
    join
  endtask

  task automatic wait_resps(input int count);
    int n;
    n = 0;
    while (resp_core_q.size() < count && n < TIMEOUT) begin
      @(posedge CLK);
      n++;
    end
    if (resp_core_q.size() < count) begin
      other_errs++;
      $display("timed out waiting for %0d responses, got %0d", count, resp_core_q.size());
    end
  endtask

  task automatic check_val(input string name, input logic [`DATA_W-1:0] got,
                           input logic [`DATA_W-1:0] exp);
    if (got !== exp) begin
      value_errs++;
      $display("Fail %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_resp(input int idx, input int core, input logic [`DATA_W-1:0] data);
    if (idx >= resp_core_q.size()) begin
      other_errs++;
      $display("response %0d is missing", idx);
    end else begin
      check_val("resp core", resp_core_q[idx], core);
      check_val("resp.rdata", resp_data_q[idx], data);
    end
  endtask

  task automatic check_snoop(input int idx, input int core, input logic [`ADDR_W-1:0] addr,
                             input logic inv);
    if (idx >= snp_core_q.size()) begin
      other_errs++;
      $display("snoop %0d never reached core %0d", idx, core);
    end else begin
      check_val("snoop core", snp_core_q[idx], core);
      check_val("snoop_req.addr", `DATA_W'(snp_addr_q[idx]), `DATA_W'(addr));
      check_val("snoop_req.inv", `DATA_W'(snp_inv_q[idx]), `DATA_W'(inv));
    end
  endtask

  task automatic check_no_snoop();
    if (snp_core_q.size() != 0) begin
      other_errs++;
      $display("instruction fetch caused a snoop");
    end
  endtask

  task automatic test_write_read();
    clear_logs();
    for (int i = 0; i < 4; i++) begin
      wr_addr[i] = `ADDR_W'(16 * i + 3 + $urandom_range(11, 0));
      wr_data[i] = $urandom;
      send_req(0, REQ_DWRITE, wr_addr[i], wr_data[i]);
      wait_resps(i + 1);
    end
    for (int i = 0; i < 4; i++) begin
      check_resp(i, 0, '0);
      check_snoop(i, 1, wr_addr[i], 1'b1);
    end
    clear_logs();
    for (int i = 0; i < 4; i++) begin
      send_req(1, REQ_DREAD, wr_addr[i], '0);
      wait_resps(i + 1);
      check_resp(i, 1, wr_data[i]);
      check_snoop(i, 0, wr_addr[i], 1'b0);
    end
  endtask

  task automatic test_fetch();
    clear_logs();
    send_req(0, REQ_IFETCH, wr_addr[2], '0);
    wait_resps(1);
    send_req(1, REQ_IFETCH, wr_addr[3], '0);
    wait_resps(2);
    check_resp(0, 0, wr_data[2]);
    check_resp(1, 1, wr_data[3]);
    check_no_snoop();
  endtask

  task automatic test_dirty_hit();
    logic [`DATA_W-1:0] dword;
    dword = wr_data[0] ^ 32'h5a5a_0001;
    dirty_addr[1] = wr_addr[0];
    dirty_data[1] = dword;
    dirty_on[1]   = 1'b1;
    clear_logs();
    send_req(0, REQ_DREAD, wr_addr[0], '0);
    wait_resps(1);
    check_resp(0, 0, dword);
    check_snoop(0, 1, wr_addr[0], 1'b0);
    // RAM must now hold the written-back word
    clear_logs();
    send_req(1, REQ_IFETCH, wr_addr[0], '0);
    wait_resps(1);
    check_resp(0, 1, dword);
    check_no_snoop();
    wr_data[0] = dword;
  endtask

  task automatic test_arbitration();
    drive_reset();
    clear_logs();
    // core 0 goes first after reset
    send_pair(REQ_DREAD, wr_addr[1], REQ_DREAD, wr_addr[3]);
    // data beats fetch
    send_pair(REQ_IFETCH, wr_addr[2], REQ_DREAD, wr_addr[0]);
    // core 0 won the last fetch
    send_pair(REQ_IFETCH, wr_addr[3], REQ_IFETCH, wr_addr[1]);
    wait_resps(6);
    check_resp(0, 0, wr_data[1]);
    check_resp(1, 1, wr_data[3]);
    check_resp(2, 1, wr_data[0]);
    check_resp(3, 0, wr_data[2]);
    check_resp(4, 1, wr_data[1]);
    check_resp(5, 0, wr_data[3]);
  endtask

  task automatic test_backpressure();
    int n;
    clear_logs();
    @(negedge CLK);
    resp_ready[0] = 1'b0;
    send_req(0, REQ_DREAD, wr_addr[1], '0);
    send_req(1, REQ_DREAD, wr_addr[2], '0);
    n = 0;
    while (!resp_valid[0] && n < TIMEOUT) begin
      @(posedge CLK);
      n++;
    end
    if (!resp_valid[0]) begin
      other_errs++;
      $display("held response never appeared on core 0");
    end
    repeat (6) begin
      @(posedge CLK);
      if (!resp_valid[0]) begin
        other_errs++;
        $display("response on core 0 dropped before it was taken");
      end
      check_val("resp[0].rdata", resp[0].rdata, wr_data[1]);
    end
    if (resp_core_q.size() != 0) begin
      other_errs++;
      $display("a response completed while core 0 was stalled");
    end
    @(negedge CLK);
    resp_ready[0] = 1'b1;
    wait_resps(2);
    check_resp(0, 0, wr_data[1]);
    check_resp(1, 1, wr_data[2]);
  endtask

  initial begin
    void'($urandom(32'h4d92));
    value_errs = 0;
    other_errs = 0;
    nRST = 1'b0;
    req_valid = '0;
    resp_ready = '1;
    snoop_ready = '1;
    snoop_resp_valid = '0;
    for (int c = 0; c < `NUM_CORES; c++) begin
      req[c] = '0;
      snoop_resp[c] = '0;
      dirty_on[c] = 1'b0;
      dirty_addr[c] = '0;
      dirty_data[c] = '0;
      busy[c] = 1'b0;
      delay[c] = 0;
    end
    drive_reset();
    test_write_read();
    test_fetch();
    test_dirty_hit();
    test_arbitration();
    test_backpressure();
    repeat (4) @(posedge CLK);
    $display("summary: %0d value errors, %0d other errors", value_errs, other_errs);
    if (value_errs == 0 && other_errs == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

/* bench/tb_clock.sv */
// testbench clock
// free-running clock with a period of 4
module tb_clock (
  output logic CLK
);

  initial begin
    CLK = 1'b0;
  end

  always #2 CLK = ~CLK;

endmodule

/* hdl/bus_arbiter.sv */
// bus arbiter
// one core request per cycle, data requests before instruction fetches,
// alternating priority between the cores within each class
`include "coherence_settings.svh"

module bus_arbiter (
  input  logic                     CLK,
  input  logic                     nRST,
  input  coherence_pkg::mem_req_t  req [`NUM_CORES],
  input  logic [`NUM_CORES-1:0]    req_valid,
  output logic [`NUM_CORES-1:0]    req_ready,
  output coherence_pkg::mem_req_t  grant,
  output logic                     grant_valid,
  input  logic                     grant_ready
);
  import coherence_pkg::*;

  logic [`NUM_CORES-1:0] data_req;
  logic [`NUM_CORES-1:0] fetch_req;
  logic [`NUM_CORES-1:0] cand;
  logic                  any_data;
  logic                  last;
  logic                  win;
  // last winner per class
  logic                  last_data;
  logic                  last_fetch;

  always_comb begin
    for (int i = 0; i < `NUM_CORES; i++) begin
      data_req[i]  = req_valid[i] && (req[i].kind != REQ_IFETCH);
      fetch_req[i] = req_valid[i] && (req[i].kind == REQ_IFETCH);
    end
    any_data = |data_req;
    cand     = any_data ? data_req : fetch_req;
    last     = any_data ? last_data : last_fetch;

    // both ask: the core that lost last time
    if (cand == 2'b11) begin
      win = ~last;
    end else begin
      win = cand[1];
    end

    grant       = req[win];
    grant.core  = win;
    grant_valid = |cand;

    req_ready[0] = grant_ready && grant_valid && !win;
    req_ready[1] = grant_ready && grant_valid && win;
  end

  // start as if core 1 won, so core 0 goes first
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      last_data  <= 1'b1;
      last_fetch <= 1'b1;
    end else if (grant_valid && grant_ready) begin
      if (any_data) begin
        last_data <= win;
      end else begin
        last_fetch <= win;
      end
    end
  end

endmodule

/* hdl/coherence_pkg.sv */
// coherence types
// request, response and snoop payloads shared by the controller stages
`include "coherence_settings.svh"

package coherence_pkg;

  typedef enum logic [1:0] {
    REQ_DREAD  = 2'b00,
    REQ_DWRITE = 2'b01,
    REQ_IFETCH = 2'b10
  } req_kind_e;

  // core field is filled in by the arbiter
  typedef struct packed {
    req_kind_e           kind;
    logic                core;
    logic [`ADDR_W-1:0]  addr;
    logic [`DATA_W-1:0]  wdata;
  } mem_req_t;

  // zero for writes
  typedef struct packed {
    logic [`DATA_W-1:0]  rdata;
  } mem_resp_t;

  typedef struct packed {
    logic [`ADDR_W-1:0]  addr;
    logic                inv;
  } snoop_req_t;

  typedef struct packed {
    logic                hit;
    logic                dirty;
    logic [`DATA_W-1:0]  data;
  } snoop_resp_t;

  // snoop stage to RAM stage
  typedef struct packed {
    mem_req_t            req;
    logic                supplied;
    logic [`DATA_W-1:0]  sdata;
  } snoop_result_t;

endpackage

/* hdl/coherence_settings.svh */
// memory system sizes and timing
// word-addressed shared RAM behind the two-core controller
`ifndef COHERENCE_SETTINGS_SVH
`define COHERENCE_SETTINGS_SVH

// word address width
`define ADDR_W 12

// data word width
`define DATA_W 32

// cycles from accepted RAM access to data valid
`define RAM_LATENCY 2

// fixed, array sizes only
`define NUM_CORES 2

`endif

/* hdl/main_ram.sv */
// shared RAM
// word-addressed array with a fixed access latency, one access at a time,
// rvalid pulses once when the access completes
`include "coherence_settings.svh"

module main_ram (
  input  logic               CLK,
  input  logic               nRST,
  input  logic [`ADDR_W-1:0] ram_addr,
  input  logic [`DATA_W-1:0] ram_wdata,
  input  logic               ram_wen,
  input  logic               ram_en,
  output logic [`DATA_W-1:0] ram_rdata,
  output logic               ram_rvalid
);

  localparam int CNT_W = $clog2(`RAM_LATENCY + 1);

  logic [`DATA_W-1:0] mem [2**`ADDR_W];
  logic [CNT_W-1:0]   cnt;
  logic [`ADDR_W-1:0] addr_q;
  logic [`DATA_W-1:0] wdata_q;
  logic               wen_q;

  // ram_en is ignored while busy
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      cnt        <= '0;
      ram_rvalid <= 1'b0;
    end else begin
      ram_rvalid <= 1'b0;
      if (cnt != '0) begin
        cnt <= cnt - 1'b1;
        if (cnt == CNT_W'(1)) begin
          ram_rvalid <= 1'b1;
        end
      end else if (ram_en) begin
        cnt <= CNT_W'(`RAM_LATENCY);
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (cnt == '0 && ram_en) begin
      addr_q  <= ram_addr;
      wdata_q <= ram_wdata;
      wen_q   <= ram_wen;
    end
    // write lands at end of latency
    if (cnt == CNT_W'(1)) begin
      if (wen_q) begin
        mem[addr_q] <= wdata_q;
      end else begin
        ram_rdata <= mem[addr_q];
      end
    end
  end

endmodule

/* hdl/memory_control.sv */
// two-core memory controller
// in-order pipeline of arbitration, snoop and RAM access stages
// in front of one shared RAM, with snoop-based coherence
`include "coherence_settings.svh"

module memory_control (
  input  logic                        CLK,
  input  logic                        nRST,
  input  coherence_pkg::mem_req_t     req [`NUM_CORES],
  input  logic [`NUM_CORES-1:0]       req_valid,
  output logic [`NUM_CORES-1:0]       req_ready,
  output coherence_pkg::mem_resp_t    resp [`NUM_CORES],
  output logic [`NUM_CORES-1:0]       resp_valid,
  input  logic [`NUM_CORES-1:0]       resp_ready,
  output coherence_pkg::snoop_req_t   snoop_req [`NUM_CORES],
  output logic [`NUM_CORES-1:0]       snoop_valid,
  input  logic [`NUM_CORES-1:0]       snoop_ready,
  input  coherence_pkg::snoop_resp_t  snoop_resp [`NUM_CORES],
  input  logic [`NUM_CORES-1:0]       snoop_resp_valid
);
  import coherence_pkg::*;

  mem_req_t           grant;
  logic               grant_valid;
  logic               grant_ready;
  mem_req_t           snp_req;
  logic               snp_valid;
  logic               snp_ready;
  snoop_result_t      result;
  logic               result_valid;
  logic               result_ready;
  snoop_result_t      seq_in;
  logic               seq_valid;
  logic               seq_ready;
  logic [`ADDR_W-1:0] ram_addr;
  logic [`DATA_W-1:0] ram_wdata;
  logic [`DATA_W-1:0] ram_rdata;
  logic               ram_wen;
  logic               ram_en;
  logic               ram_rvalid;

  bus_arbiter arb (
    .CLK, .nRST, .req, .req_valid, .req_ready,
    .grant, .grant_valid, .grant_ready
  );

  // arbitration to snoop
  pipe_reg #(.payload_t(mem_req_t)) arb_reg (
    .CLK, .nRST,
    .in_data(grant), .in_valid(grant_valid), .in_ready(grant_ready),
    .out_data(snp_req), .out_valid(snp_valid), .out_ready(snp_ready)
  );

  snoop_unit snp (
    .CLK, .nRST,
    .in_req(snp_req), .in_valid(snp_valid), .in_ready(snp_ready),
    .snoop_req, .snoop_valid, .snoop_ready, .snoop_resp, .snoop_resp_valid,
    .result, .result_valid, .result_ready
  );

  // snoop to RAM access
  pipe_reg #(.payload_t(snoop_result_t)) snp_reg (
    .CLK, .nRST,
    .in_data(result), .in_valid(result_valid), .in_ready(result_ready),
    .out_data(seq_in), .out_valid(seq_valid), .out_ready(seq_ready)
  );

  ram_sequencer seq (
    .CLK, .nRST,
    .in_result(seq_in), .in_valid(seq_valid), .in_ready(seq_ready),
    .ram_addr, .ram_wdata, .ram_wen, .ram_en, .ram_rdata, .ram_rvalid,
    .resp, .resp_valid, .resp_ready
  );

  main_ram ram (
    .CLK, .nRST, .ram_addr, .ram_wdata, .ram_wen, .ram_en, .ram_rdata, .ram_rvalid
  );

endmodule

/* hdl/pipe_reg.sv */
// pipeline register
// one-entry valid/ready stage, full throughput, any payload type
module pipe_reg #(
  parameter type payload_t = logic
) (
  input  logic     CLK,
  input  logic     nRST,
  input  payload_t in_data,
  input  logic     in_valid,
  output logic     in_ready,
  output payload_t out_data,
  output logic     out_valid,
  input  logic     out_ready
);

  // free slot, or the held entry leaves this cycle
  assign in_ready = !out_valid || out_ready;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      out_valid <= 1'b0;
    end else if (in_ready) begin
      out_valid <= in_valid;
    end
  end

  always_ff @(posedge CLK) begin
    if (in_valid && in_ready) begin
      out_data <= in_data;
    end
  end

endmodule

/* hdl/ram_sequencer.sv */
// RAM stage
// runs the write-back of supplied dirty data, then the request's own
// access, and holds the response for the requesting core
`include "coherence_settings.svh"

module ram_sequencer (
  input  logic                          CLK,
  input  logic                          nRST,
  input  coherence_pkg::snoop_result_t  in_result,
  input  logic                          in_valid,
  output logic                          in_ready,
  output logic [`ADDR_W-1:0]            ram_addr,
  output logic [`DATA_W-1:0]            ram_wdata,
  output logic                          ram_wen,
  output logic                          ram_en,
  input  logic [`DATA_W-1:0]            ram_rdata,
  input  logic                          ram_rvalid,
  output coherence_pkg::mem_resp_t      resp [`NUM_CORES],
  output logic [`NUM_CORES-1:0]         resp_valid,
  input  logic [`NUM_CORES-1:0]         resp_ready
);
  import coherence_pkg::*;

  typedef enum logic [2:0] {
    Q_IDLE, Q_WB, Q_WB_WAIT, Q_ACC, Q_ACC_WAIT, Q_RESP
  } state_e;

  state_e        state;
  snoop_result_t cur_q;
  mem_resp_t     resp_q;

  assign in_ready  = (state == Q_IDLE);
  // one-cycle start pulse per access
  assign ram_en    = (state == Q_WB) || (state == Q_ACC);
  assign ram_wen   = (state == Q_WB) ||
                     (state == Q_ACC && cur_q.req.kind == REQ_DWRITE);
  assign ram_addr  = cur_q.req.addr;
  assign ram_wdata = (state == Q_WB) ? cur_q.sdata : cur_q.req.wdata;

  always_comb begin
    resp_valid = '0;
    for (int i = 0; i < `NUM_CORES; i++) begin
      resp[i] = resp_q;
    end
    resp_valid[cur_q.req.core] = (state == Q_RESP);
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state <= Q_IDLE;
    end else begin
      case (state)
        Q_IDLE: begin
          if (in_valid) begin
            state <= in_result.supplied ? Q_WB : Q_ACC;
          end
        end
        Q_WB:       state <= Q_WB_WAIT;
        Q_WB_WAIT:  if (ram_rvalid) state <= Q_ACC;
        Q_ACC:      state <= Q_ACC_WAIT;
        Q_ACC_WAIT: if (ram_rvalid) state <= Q_RESP;
        default: begin
          if (resp_ready[cur_q.req.core]) begin
            state <= Q_IDLE;
          end
        end
      endcase
    end
  end

  always_ff @(posedge CLK) begin
    if (in_valid && in_ready) begin
      cur_q <= in_result;
    end
    if (state == Q_ACC_WAIT && ram_rvalid) begin
      if (cur_q.req.kind == REQ_DWRITE) begin
        resp_q.rdata <= '0;
      end else if (cur_q.supplied) begin
        // cache-to-cache word wins over RAM
        resp_q.rdata <= cur_q.sdata;
      end else begin
        resp_q.rdata <= ram_rdata;
      end
    end
  end

endmodule

/* hdl/snoop_unit.sv */
// snoop stage
// data requests snoop the other core and wait for its answer,
// instruction fetches pass straight through
`include "coherence_settings.svh"

module snoop_unit (
  input  logic                          CLK,
  input  logic                          nRST,
  input  coherence_pkg::mem_req_t       in_req,
  input  logic                          in_valid,
  output logic                          in_ready,
  output coherence_pkg::snoop_req_t     snoop_req [`NUM_CORES],
  output logic [`NUM_CORES-1:0]         snoop_valid,
  input  logic [`NUM_CORES-1:0]         snoop_ready,
  input  coherence_pkg::snoop_resp_t    snoop_resp [`NUM_CORES],
  input  logic [`NUM_CORES-1:0]         snoop_resp_valid,
  output coherence_pkg::snoop_result_t  result,
  output logic                          result_valid,
  input  logic                          result_ready
);
  import coherence_pkg::*;

  typedef enum logic [1:0] {S_IDLE, S_ISSUE, S_WAIT, S_FWD} state_e;

  state_e             state;
  state_e             state_next;
  mem_req_t           req_q;
  logic               supplied_q;
  logic [`DATA_W-1:0] sdata_q;
  logic               other;
  logic               is_fetch;
  logic               answer;

  assign other    = ~req_q.core;
  assign is_fetch = (in_req.kind == REQ_IFETCH);

  always_comb begin
    state_next   = state;
    in_ready     = 1'b0;
    result_valid = 1'b0;
    snoop_valid  = '0;
    answer       = 1'b0;
    result.req      = req_q;
    result.supplied = supplied_q;
    result.sdata    = sdata_q;
    for (int i = 0; i < `NUM_CORES; i++) begin
      snoop_req[i].addr = req_q.addr;
      snoop_req[i].inv  = (req_q.kind == REQ_DWRITE);
    end

    case (state)
      S_IDLE: begin
        if (is_fetch) begin
          // fetch bypass
          result.req      = in_req;
          result.supplied = 1'b0;
          result.sdata    = '0;
          result_valid    = in_valid;
          in_ready        = result_ready;
        end else begin
          in_ready = 1'b1;
          if (in_valid) begin
            state_next = S_ISSUE;
          end
        end
      end
      S_ISSUE: begin
        snoop_valid[other] = 1'b1;
        if (snoop_ready[other]) begin
          // answer may come with the accept
          answer     = snoop_resp_valid[other];
          state_next = answer ? S_FWD : S_WAIT;
        end
      end
      S_WAIT: begin
        answer = snoop_resp_valid[other];
        if (answer) begin
          state_next = S_FWD;
        end
      end
      default: begin
        result_valid = 1'b1;
        if (result_ready) begin
          state_next = S_IDLE;
        end
      end
    endcase
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state <= S_IDLE;
    end else begin
      state <= state_next;
    end
  end

  always_ff @(posedge CLK) begin
    if (state == S_IDLE && in_valid && !is_fetch) begin
      req_q <= in_req;
    end
    // only a dirty hit on a read supplies data
    if (answer) begin
      supplied_q <= (req_q.kind == REQ_DREAD) && snoop_resp[other].hit &&
                    snoop_resp[other].dirty;
      sdata_q    <= snoop_resp[other].data;
    end
  end

endmodule

/* run.sh */
#!/bin/sh
# build the memory controller testbench with Verilator and run it
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f src.f \
  --top-module memory_control_tb -o memory_control_sim &&
./obj_dir/memory_control_sim | tee /dev/stderr | grep -q "Regression passed" &&
echo "simulation ok" ||
{ echo "simulation not ok"; exit 1; }

/* src.f */
+incdir+hdl
hdl/coherence_pkg.sv
hdl/pipe_reg.sv
hdl/bus_arbiter.sv
hdl/snoop_unit.sv
hdl/ram_sequencer.sv
hdl/main_ram.sv
hdl/memory_control.sv
bench/tb_clock.sv
bench/memory_control_assert.sv
bench/memory_control_tb.sv
